/* common/fp_div16_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// IEEE single-precision operands only
// denormals are read as zero, NaN output is the canonical quiet NaN
// ~~~~~~~~~~~~~~~~~~~~

package fp_div16_pkg;

  // operand fields
  localparam int mant_w = 24;
  localparam int exp_w = 8;
  localparam int exp_bias = 127;

  // recurrence sizing: 1 integer bit plus 7 hex digits
  localparam int rem_w = 28;
  localparam int n_steps = 8;
  localparam int quo_w = 29;

  localparam int tag_w = 8;

  localparam logic [31:0] qnan_bits = 32'h7fc0_0000;

  typedef enum logic [2:0] {
    rm_trunc = 3'd0,
    rm_round = 3'd1,
    rm_even  = 3'd2,
    rm_plus  = 3'd3,
    rm_minus = 3'd4
  } round_mode_e;

  typedef enum logic [1:0] {
    cls_zero   = 2'd0,
    cls_normal = 2'd1,
    cls_inf    = 2'd2,
    cls_nan    = 2'd3
  } fp_class_e;

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_iterate = 2'd1,
    st_done    = 2'd2
  } div_state_e;

  typedef struct packed {
    logic [31:0]      a;
    logic [31:0]      b;
    round_mode_e      rmode;
    logic [tag_w-1:0] tag;
  } div_req_t;

  typedef struct packed {
    logic [31:0]      result;
    logic [tag_w-1:0] tag;
  } div_rsp_t;

  // mant carries the hidden bit
  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [mant_w-1:0] mant;
    fp_class_e         cls;
  } fp_operand_t;

endpackage

/* divider/digit_select.sv */
// ~~~~~~~~~~~~~~~~~~~~
// combinational, assumes mult is strictly increasing
// rem must stay below 16 times the divisor
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module digit_select (
  input  logic [fp_div16_pkg::rem_w-1:0]        rem,
  input  logic [15:1][fp_div16_pkg::rem_w-1:0] mult,
  output logic [3:0]                            digit,
  output logic [fp_div16_pkg::rem_w-1:0]        rem_next
);

  logic [15:1]                    ge;
  logic [15:1]                    sel;
  logic [fp_div16_pkg::rem_w-1:0] sub;

  // all comparisons in parallel, ge forms a thermometer code
  always_comb begin
    for (int k = 1; k <= 15; k++) begin
      ge[k] = rem >= mult[k];
    end
  end

  // one-hot edge of the thermometer
  always_comb begin
    for (int k = 1; k < 15; k++) begin
      sel[k] = ge[k] & ~ge[k+1];
    end
    sel[15] = ge[15];
  end

  // and-or mux over the one-hot select
  always_comb begin
    digit = 4'd0;
    sub = '0;
    for (int k = 1; k <= 15; k++) begin
      if (sel[k]) begin
        digit = digit | 4'(k);
        sub = sub | mult[k];
      end
    end
  end

  // digit 0 leaves sub at zero
  assign rem_next = rem - sub;

endmodule

/* divider/div_iterate.sv */
// ~~~~~~~~~~~~~~~~~~~~
// one operation at a time, load only while idle
// quotient is floor(dividend * 2^28 / divisor)
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module div_iterate (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             load,
  input  logic [fp_div16_pkg::mant_w-1:0]  dividend,
  input  logic [fp_div16_pkg::mant_w-1:0]  divisor,
  output logic [fp_div16_pkg::quo_w-1:0]   quo,
  output logic                             sticky,
  output logic                             q_valid
);

  fp_div16_pkg::div_state_e                state_q;
  logic [$clog2(fp_div16_pkg::n_steps)-1:0] step_cnt;
  logic [fp_div16_pkg::rem_w-1:0]          rem_q;
  logic [fp_div16_pkg::rem_w-1:0]          rem_next;
  logic [3:0]                              digit;
  logic [15:1][fp_div16_pkg::rem_w-1:0]    mult;
  logic                                    last_step;

  divisor_multiples i_mult (
    .clk     (clk),
    .load    (load),
    .divisor (divisor),
    .mult    (mult)
  );

  digit_select i_select (
    .rem      (rem_q),
    .mult     (mult),
    .digit    (digit),
    .rem_next (rem_next)
  );

  assign last_step = step_cnt == $bits(step_cnt)'(fp_div16_pkg::n_steps - 1);

  // control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= fp_div16_pkg::st_idle;
      step_cnt <= '0;
    end else begin
      case (state_q)
        fp_div16_pkg::st_idle: begin
          if (load) begin
            state_q <= fp_div16_pkg::st_iterate;
            step_cnt <= '0;
          end
        end
        fp_div16_pkg::st_iterate: begin
          step_cnt <= step_cnt + 1'b1;
          if (last_step) begin
            state_q <= fp_div16_pkg::st_done;
          end
        end
        default: begin
          state_q <= fp_div16_pkg::st_idle;
        end
      endcase
    end
  end

  // datapath, first step sees the dividend unshifted
  always_ff @(posedge clk) begin
    if (state_q == fp_div16_pkg::st_idle && load) begin
      rem_q <= fp_div16_pkg::rem_w'(dividend);
      quo <= '0;
    end else if (state_q == fp_div16_pkg::st_iterate) begin
      // rem_next is below the divisor, so the top nibble is free
      rem_q <= {rem_next[fp_div16_pkg::rem_w-5:0], 4'h0};
      quo <= {quo[fp_div16_pkg::quo_w-5:0], digit};
    end
  end

  assign sticky = |rem_q;
  assign q_valid = state_q == fp_div16_pkg::st_done;

endmodule

/* divider/divisor_multiples.sv */
// ~~~~~~~~~~~~~~~~~~~~
// table is held between loads, valid one cycle after load
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module divisor_multiples (
  input  logic                                  clk,
  input  logic                                  load,
  input  logic [fp_div16_pkg::mant_w-1:0]       divisor,
  output logic [15:1][fp_div16_pkg::rem_w-1:0] mult
);

  logic [fp_div16_pkg::rem_w-1:0]        d1;
  logic [fp_div16_pkg::rem_w-1:0]        d2;
  logic [fp_div16_pkg::rem_w-1:0]        d4;
  logic [fp_div16_pkg::rem_w-1:0]        d8;
  logic [fp_div16_pkg::rem_w-1:0]        d16;
  logic [15:1][fp_div16_pkg::rem_w-1:0] mult_d;

  // shifted copies of the divisor
  assign d1 = fp_div16_pkg::rem_w'(divisor);
  assign d2 = d1 << 1;
  assign d4 = d1 << 2;
  assign d8 = d1 << 3;
  assign d16 = d1 << 4;

  always_comb begin
    // powers of two
    mult_d[1] = d1;
    mult_d[2] = d2;
    mult_d[4] = d4;
    mult_d[8] = d8;
    // odd multiples from adders
    mult_d[3] = d2 + d1;
    mult_d[5] = d4 + d1;
    mult_d[7] = d8 - d1;
    mult_d[9] = d8 + d1;
    mult_d[11] = d8 + d2 + d1;
    mult_d[13] = d8 + d4 + d1;
    mult_d[15] = d16 - d1;
    // remaining evens are shifted odds
    mult_d[6] = mult_d[3] << 1;
    mult_d[10] = mult_d[5] << 1;
    mult_d[12] = mult_d[3] << 2;
    mult_d[14] = mult_d[7] << 1;
  end

  always_ff @(posedge clk) begin
    if (load) begin
      mult <= mult_d;
    end
  end

endmodule

/* fp_div16.f */
+incdir+tests
common/fp_div16_pkg.sv
hw/fp_unpack.sv
divider/divisor_multiples.sv
divider/digit_select.sv
divider/div_iterate.sv
hw/round_pack.sv
hw/fp_div16_top.sv
tests/fp_div16_tb.sv

/* hw/fp_div16_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// one request in flight, fixed 10 cycle latency to out_en
// start is ignored while rdy is low
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fp_div16_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  fp_div16_pkg::div_req_t     req,
  output logic                       rdy,
  output fp_div16_pkg::div_rsp_t     rsp,
  output logic                       out_en,
  input  logic                       out_can
);

  fp_div16_pkg::fp_operand_t      op_a_in;
  fp_div16_pkg::fp_operand_t      op_b_in;
  fp_div16_pkg::fp_operand_t      op_a_q;
  fp_div16_pkg::fp_operand_t      op_b_q;
  fp_div16_pkg::round_mode_e      rmode_q;
  logic [fp_div16_pkg::tag_w-1:0] tag_q;
  logic                           accept;
  logic [fp_div16_pkg::quo_w-1:0] quo;
  logic                           sticky;
  logic                           q_valid;
  logic                           res_valid;

  fp_unpack i_unpack_a (
    .bits (req.a),
    .op   (op_a_in)
  );

  fp_unpack i_unpack_b (
    .bits (req.b),
    .op   (op_b_in)
  );

  assign accept = start & rdy;

  // side info for the final stage
  always_ff @(posedge clk) begin
    if (accept) begin
      op_a_q <= op_a_in;
      op_b_q <= op_b_in;
      rmode_q <= req.rmode;
      tag_q <= req.tag;
    end
  end

  div_iterate i_iterate (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (accept),
    .dividend (op_a_in.mant),
    .divisor  (op_b_in.mant),
    .quo      (quo),
    .sticky   (sticky),
    .q_valid  (q_valid)
  );

  round_pack i_round (
    .clk       (clk),
    .rst_n     (rst_n),
    .q_valid   (q_valid),
    .quo       (quo),
    .sticky    (sticky),
    .op_a      (op_a_q),
    .op_b      (op_b_q),
    .rmode     (rmode_q),
    .tag       (tag_q),
    .res_valid (res_valid),
    .rsp       (rsp)
  );

  // handshake, rdy returns on the edge that takes the result
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy <= 1'b1;
      out_en <= 1'b0;
    end else begin
      if (accept) begin
        rdy <= 1'b0;
      end else if (out_en && out_can) begin
        rdy <= 1'b1;
      end
      if (res_valid) begin
        out_en <= 1'b1;
      end else if (out_can) begin
        out_en <= 1'b0;
      end
    end
  end

endmodule

/* hw/fp_unpack.sv */
// ~~~~~~~~~~~~~~~~~~~~
// combinational, denormals classify as zero
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fp_unpack (
  input  logic [31:0]               bits,
  output fp_div16_pkg::fp_operand_t op
);

  logic [fp_div16_pkg::exp_w-1:0]  exp_f;
  logic [fp_div16_pkg::mant_w-2:0] frac_f;

  assign exp_f = bits[30:23];
  assign frac_f = bits[22:0];

  always_comb begin
    op.sign = bits[31];
    op.exp = exp_f;
    op.mant = {exp_f != '0, frac_f};
    if (exp_f == '0) begin
      op.cls = fp_div16_pkg::cls_zero;
    end else if (exp_f == '1) begin
      op.cls = (frac_f == '0) ? fp_div16_pkg::cls_inf : fp_div16_pkg::cls_nan;
    end else begin
      op.cls = fp_div16_pkg::cls_normal;
    end
  end

endmodule

/* hw/round_pack.sv */
// ~~~~~~~~~~~~~~~~~~~~
// overflow gives infinity in every mode, underflow flushes to zero
// result held until the next q_valid
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module round_pack (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              q_valid,
  input  logic [fp_div16_pkg::quo_w-1:0]    quo,
  input  logic                              sticky,
  input  fp_div16_pkg::fp_operand_t         op_a,
  input  fp_div16_pkg::fp_operand_t         op_b,
  input  fp_div16_pkg::round_mode_e         rmode,
  input  logic [fp_div16_pkg::tag_w-1:0]    tag,
  output logic                              res_valid,
  output fp_div16_pkg::div_rsp_t            rsp
);

  logic                             lead;
  logic [fp_div16_pkg::mant_w-2:0]  frac;
  logic                             rnd_bit;
  logic                             stk;
  logic                             sign;
  logic                             inc;
  logic [fp_div16_pkg::mant_w-1:0]  frac_rnd;
  logic [fp_div16_pkg::exp_w+1:0]   exp_calc;
  logic                             ovf;
  logic                             unf;
  logic                             a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
  logic                             spec_nan, spec_inf, spec_zero;
  logic [31:0]                      result;

  // normalize on the integer bit
  assign lead = quo[fp_div16_pkg::quo_w-1];
  assign frac = lead ? quo[27:5] : quo[26:4];
  assign rnd_bit = lead ? quo[4] : quo[3];
  assign stk = sticky | (lead ? |quo[3:0] : |quo[2:0]);
  assign sign = op_a.sign ^ op_b.sign;

  always_comb begin
    case (rmode)
      fp_div16_pkg::rm_round: inc = rnd_bit;
      fp_div16_pkg::rm_even:  inc = rnd_bit & (stk | frac[0]);
      fp_div16_pkg::rm_plus:  inc = ~sign & (rnd_bit | stk);
      fp_div16_pkg::rm_minus: inc = sign & (rnd_bit | stk);
      default:                inc = 1'b0;
    endcase
  end

  // carry out lands in the top bit, fraction field is then all zero
  assign frac_rnd = {1'b0, frac} + fp_div16_pkg::mant_w'(inc);

  // two's complement in exp_w+2 bits
  assign exp_calc = {2'b00, op_a.exp} - {2'b00, op_b.exp}
                  + (fp_div16_pkg::exp_w + 2)'(fp_div16_pkg::exp_bias)
                  - {{(fp_div16_pkg::exp_w + 1){1'b0}}, ~lead}
                  + {{(fp_div16_pkg::exp_w + 1){1'b0}}, frac_rnd[fp_div16_pkg::mant_w-1]};

  assign ovf = ~exp_calc[fp_div16_pkg::exp_w+1] && exp_calc[fp_div16_pkg::exp_w:0] >= 9'd255;
  assign unf = exp_calc[fp_div16_pkg::exp_w+1] || exp_calc == '0;

  // operand classes
  assign a_nan = op_a.cls == fp_div16_pkg::cls_nan;
  assign b_nan = op_b.cls == fp_div16_pkg::cls_nan;
  assign a_inf = op_a.cls == fp_div16_pkg::cls_inf;
  assign b_inf = op_b.cls == fp_div16_pkg::cls_inf;
  assign a_zero = op_a.cls == fp_div16_pkg::cls_zero;
  assign b_zero = op_b.cls == fp_div16_pkg::cls_zero;

  assign spec_nan = a_nan | b_nan | (a_zero & b_zero) | (a_inf & b_inf);
  assign spec_inf = a_inf | b_zero;
  assign spec_zero = a_zero | b_inf;

  always_comb begin
    if (spec_nan) begin
      result = fp_div16_pkg::qnan_bits;
    end else if (spec_inf || (!spec_zero && ovf)) begin
      result = {sign, {fp_div16_pkg::exp_w{1'b1}}, 23'd0};
    end else if (spec_zero || unf) begin
      result = {sign, 31'd0};
    end else begin
      result = {sign, exp_calc[fp_div16_pkg::exp_w-1:0], frac_rnd[fp_div16_pkg::mant_w-2:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= q_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (q_valid) begin
      rsp.result <= result;
      rsp.tag <= tag;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fp_div16_tb -f fp_div16.f \
  -o fp_div16_sim > build.log 2>&1 &&
  ./obj_dir/fp_div16_sim > sim.log 2>&1 ||
  { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Done: errors found" sim.log &&
  { echo "FAIL"; exit 1; } ||
  { echo "PASS"; exit 0; }

/* tests/fp_div16_model.svh */
// ~~~~~~~~~~~~~~~~~~~~
// expected results for the divider, included inside the testbench module
// denormals read as zero, overflow is infinity in every mode
// ~~~~~~~~~~~~~~~~~~~~

`ifndef FP_DIV16_MODEL_SVH
`define FP_DIV16_MODEL_SVH

function automatic logic [31:0] model_div(input logic [31:0] a, input logic [31:0] b,
                                          input fp_div16_pkg::round_mode_e rm);
  logic        sign;
  logic        a_zero;
  logic        b_zero;
  logic        a_inf;
  logic        b_inf;
  logic        a_nan;
  logic        b_nan;
  logic [63:0] num;
  logic [63:0] den;
  logic [63:0] q;
  logic        lead;
  logic [22:0] frac;
  logic        rnd;
  logic        stk;
  logic        inc;
  logic [23:0] mant;
  int          ea;
  int          eb;
  int          e;
  sign = a[31] ^ b[31];
  ea = int'(a[30:23]);
  eb = int'(b[30:23]);
  a_zero = ea == 0;
  b_zero = eb == 0;
  a_inf = ea == 255 && a[22:0] == 23'd0;
  b_inf = eb == 255 && b[22:0] == 23'd0;
  a_nan = ea == 255 && a[22:0] != 23'd0;
  b_nan = eb == 255 && b[22:0] != 23'd0;
  if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) return 32'h7fc0_0000;
  if (a_inf || b_zero) return {sign, 8'hff, 23'd0};
  if (a_zero || b_inf) return {sign, 31'd0};
  // plain integer division of the mantissas
  num = {40'd0, 1'b1, a[22:0]} << 28;
  den = {40'd0, 1'b1, b[22:0]};
  q = num / den;
  stk = (num % den) != 64'd0;
  lead = q[28];
  frac = lead ? q[27:5] : q[26:4];
  rnd = lead ? q[4] : q[3];
  stk = stk | (lead ? (q[3:0] != 4'd0) : (q[2:0] != 3'd0));
  case (rm)
    fp_div16_pkg::rm_round: inc = rnd;
    fp_div16_pkg::rm_even:  inc = rnd & (stk | frac[0]);
    fp_div16_pkg::rm_plus:  inc = !sign & (rnd | stk);
    fp_div16_pkg::rm_minus: inc = sign & (rnd | stk);
    default:                inc = 1'b0;
  endcase
  mant = {1'b0, frac} + {23'd0, inc};
  e = ea - eb + 127 - (lead ? 0 : 1) + (mant[23] ? 1 : 0);
  if (e >= 255) return {sign, 8'hff, 23'd0};
  if (e <= 0) return {sign, 31'd0};
  return {sign, e[7:0], mant[22:0]};
endfunction

`endif

/* tests/fp_div16_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// directed and random checks of the divider against the model
// out_can stays high except in the back-pressure test
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fp_div16_tb;

  // 15 exact, 20 inexact, 12 special, 5 range, 1 back-pressure, 200 random
  localparam int n_ops = 253;
  localparam int timeout_cycles = 40 * n_ops + 4;

  logic                   clk;
  logic                   rst_n;
  logic                   start;
  fp_div16_pkg::div_req_t req;
  logic                   rdy;
  fp_div16_pkg::div_rsp_t rsp;
  logic                   out_en;
  logic                   out_can;
  logic [31:0]            rng;
  int                     err_cnt = 0;
  int                     chk_cnt = 0;
  int                     cycle_cnt = 0;

  `include "fp_div16_model.svh"

  fp_div16_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .req     (req),
    .rdy     (rdy),
    .rsp     (rsp),
    .out_en  (out_en),
    .out_can (out_can)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    chk_cnt = chk_cnt + 1;
    assert (act_v === exp_v) else begin
      err_cnt = err_cnt + 1;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    chk_cnt = chk_cnt + 1;
    assert (ok) else begin
      err_cnt = err_cnt + 1;
      $display("error: %s", what);
    end
  endtask

  // hold > 0 keeps out_can low that many cycles and tries a start meanwhile
  task automatic run_op(input string name, input logic [31:0] a, input logic [31:0] b,
                        input fp_div16_pkg::round_mode_e rm, input logic [7:0] tag,
                        input logic [31:0] expected, input int hold);
    int                     lat;
    fp_div16_pkg::div_rsp_t held;
    @(negedge clk);
    while (!rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    req.a <= a;
    req.b <= b;
    req.rmode <= rm;
    req.tag <= tag;
    start <= 1'b1;
    out_can <= (hold == 0);
    // accepting edge
    @(posedge clk);
    start <= 1'b0;
    lat = 0;
    @(negedge clk);
    while (!out_en && lat < 40) begin
      @(negedge clk);
      lat++;
    end
    compare_value({name, " latency"}, 32'd10, 32'(lat));
    compare_value(name, expected, rsp.result);
    compare_value({name, " tag"}, 32'(tag), 32'(rsp.tag));
    held = rsp;
    for (int i = 0; i < hold; i++) begin
      @(posedge clk);
      start <= (i == 1);
      req.a <= ~a;
      req.tag <= ~tag;
      @(negedge clk);
      expect_true(out_en && !rdy, {name, ": out_en dropped or rdy rose while out_can was low"});
      compare_value({name, " held result"}, held.result, rsp.result);
      compare_value({name, " held tag"}, 32'(held.tag), 32'(rsp.tag));
    end
    if (hold > 0) begin
      @(posedge clk);
      start <= 1'b0;
      out_can <= 1'b1;
      @(negedge clk);
    end
    @(negedge clk);
    expect_true(!out_en && rdy, {name, ": result not released after out_can"});
    if (hold > 0) begin
      // a start taken during the hold would show up as a second result
      for (int i = 0; i < 12; i++) begin
        @(negedge clk);
        expect_true(!out_en && rdy, {name, ": start while rdy was low was accepted"});
      end
    end
  endtask

  task automatic exact_quotients();
    fp_div16_pkg::round_mode_e rm;
    for (int m = 0; m < 5; m++) begin
      rm = fp_div16_pkg::round_mode_e'(3'(m));
      run_op("exact 6/3", 32'h40c0_0000, 32'h4040_0000, rm, 8'(16 + m), 32'h4000_0000, 0);
      run_op("exact 1/4", 32'h3f80_0000, 32'h4080_0000, rm, 8'(32 + m), 32'h3e80_0000, 0);
      run_op("exact -9/3", 32'hc110_0000, 32'h4040_0000, rm, 8'(48 + m), 32'hc040_0000, 0);
    end
  endtask

  task automatic inexact_quotients();
    fp_div16_pkg::round_mode_e rm;
    for (int m = 0; m < 5; m++) begin
      rm = fp_div16_pkg::round_mode_e'(3'(m));
      run_op("1/3", 32'h3f80_0000, 32'h4040_0000, rm, 8'(m),
             model_div(32'h3f80_0000, 32'h4040_0000, rm), 0);
      run_op("-1/3", 32'hbf80_0000, 32'h4040_0000, rm, 8'(8 + m),
             model_div(32'hbf80_0000, 32'h4040_0000, rm), 0);
      run_op("2/3", 32'h4000_0000, 32'h4040_0000, rm, 8'(16 + m),
             model_div(32'h4000_0000, 32'h4040_0000, rm), 0);
      run_op("1/7", 32'h3f80_0000, 32'h40e0_0000, rm, 8'(24 + m),
             model_div(32'h3f80_0000, 32'h40e0_0000, rm), 0);
    end
  endtask

  task automatic special_operands();
    run_op("nan a", 32'h7f80_0001, 32'h3f80_0000, fp_div16_pkg::rm_round, 8'h01, 32'h7fc0_0000, 0);
    run_op("nan b", 32'h3f80_0000, 32'hffc0_0000, fp_div16_pkg::rm_round, 8'h02, 32'h7fc0_0000, 0);
    run_op("0/0", 32'h0000_0000, 32'h8000_0000, fp_div16_pkg::rm_round, 8'h03, 32'h7fc0_0000, 0);
    run_op("inf/inf", 32'h7f80_0000, 32'hff80_0000, fp_div16_pkg::rm_round, 8'h04, 32'h7fc0_0000, 0);
    run_op("x/0", 32'h3f80_0000, 32'h0000_0000, fp_div16_pkg::rm_round, 8'h05, 32'h7f80_0000, 0);
    run_op("-x/0", 32'hbf80_0000, 32'h0000_0000, fp_div16_pkg::rm_round, 8'h06, 32'hff80_0000, 0);
    run_op("inf/x", 32'hff80_0000, 32'h4000_0000, fp_div16_pkg::rm_round, 8'h07, 32'hff80_0000, 0);
    run_op("0/x", 32'h0000_0000, 32'hc040_0000, fp_div16_pkg::rm_round, 8'h08, 32'h8000_0000, 0);
    run_op("x/inf", 32'h4040_0000, 32'h7f80_0000, fp_div16_pkg::rm_round, 8'h09, 32'h0000_0000, 0);
    run_op("-x/inf", 32'hc040_0000, 32'h7f80_0000, fp_div16_pkg::rm_round, 8'h0a, 32'h8000_0000, 0);
    run_op("denorm/x", 32'h0000_0001, 32'h3f80_0000, fp_div16_pkg::rm_round, 8'h0b, 32'h0000_0000, 0);
    run_op("x/denorm", 32'hbf80_0000, 32'h007f_ffff, fp_div16_pkg::rm_round, 8'h0c, 32'hff80_0000, 0);
  endtask

  task automatic range_limits();
    run_op("overflow", 32'h7f00_0000, 32'h3e80_0000, fp_div16_pkg::rm_round, 8'h21, 32'h7f80_0000, 0);
    run_op("overflow trunc", 32'h7f00_0000, 32'h3e80_0000, fp_div16_pkg::rm_trunc, 8'h22,
           32'h7f80_0000, 0);
    run_op("-overflow", 32'hff00_0000, 32'h3e80_0000, fp_div16_pkg::rm_minus, 8'h23, 32'hff80_0000, 0);
    run_op("underflow", 32'h0080_0000, 32'h4700_0000, fp_div16_pkg::rm_plus, 8'h24, 32'h0000_0000, 0);
    run_op("-underflow", 32'h8080_0000, 32'h4700_0000, fp_div16_pkg::rm_minus, 8'h25, 32'h8000_0000, 0);
  endtask

  task automatic hold_under_backpressure();
    run_op("back-pressure", 32'h4040_0000, 32'h3f80_0000, fp_div16_pkg::rm_even, 8'ha5,
           32'h4040_0000, 6);
  endtask

  // normal operand with exponent in 96..158
  task automatic rand_operand(output logic [31:0] v);
    logic [7:0] e;
    rng = xorshift32(rng);
    e = 8'd96 + 8'(rng[29:24] % 6'd63);
    v = {rng[31], e, rng[22:0]};
  endtask

  task automatic random_pairs();
    logic [31:0]               a;
    logic [31:0]               b;
    fp_div16_pkg::round_mode_e rm;
    for (int i = 0; i < 200; i++) begin
      rand_operand(a);
      rand_operand(b);
      rng = xorshift32(rng);
      rm = fp_div16_pkg::round_mode_e'(3'(rng[15:0] % 16'd5));
      run_op("random", a, b, rm, rng[23:16], model_div(a, b, rm), 0);
    end
  endtask

  initial begin
    rng = 32'he1c6_34ba;
    rst_n <= 1'b0;
    start <= 1'b0;
    out_can <= 1'b1;
    req <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    exact_quotients();
    inexact_quotients();
    special_operands();
    range_limits();
    hold_under_backpressure();
    random_pairs();
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
